/* list.f */
design/debug_pkg.sv
design/tap_fsm.sv
design/dbg_scan_chain.sv
design/tdo_combiner.sv
design/jtag_hub.sv
sim/jtag_hub_checker.sv
sim/jtag_hub_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP ?= jtag_hub_tb
RTL_TOP ?= jtag_hub
FILELIST ?= list.f
PASS_MSG := All checks passed

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* sim/jtag_hub_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_hub_tb;
	localparam logic [31:0] IDCODE_VALUE = 32'h1000_1c5b;
	localparam int HALF_TCK = 8;
	localparam int N_ENTRIES = 7;
	localparam int CYCLE_LIMIT = N_ENTRIES * 120 * 2 * HALF_TCK;

	// Entry modes
	localparam int MODE_NO_IR = 0;
	localparam int MODE_LOAD_IR = 1;
	localparam int MODE_TMS_RESET = 2;

	logic clk;
	logic reset;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;
	debug_pkg::cdr_ctrl_t cdr_ctrl;
	debug_pkg::prbs_ctrl_t prbs_ctrl;
	debug_pkg::cdr_stat_t cdr_stat;
	debug_pkg::prbs_stat_t prbs_stat;

	int errors;
	int cycles;
	integer seed;

	// Stimulus table
	int mode_tab [N_ENTRIES];
	logic [3:0] ir_tab [N_ENTRIES];
	int len_tab [N_ENTRIES];
	logic [63:0] din_tab [N_ENTRIES];
	logic [31:0] stat_tab [N_ENTRIES];
	logic [63:0] dout_tab [N_ENTRIES];
	logic [31:0] cdr_tab [N_ENTRIES];
	logic [15:0] prbs_tab [N_ENTRIES];

	jtag_hub #(
		.IDCODE_VALUE(IDCODE_VALUE)
	) UUT (
		.clk(clk),
		.reset_i(reset),
		.tck_i(tck),
		.tms_i(tms),
		.tdi_i(tdi),
		.trst_n_i(trst_n),
		.tdo_o(tdo),
		.cdr_ctrl_o(cdr_ctrl),
		.prbs_ctrl_o(prbs_ctrl),
		.cdr_stat_i(cdr_stat),
		.prbs_stat_i(prbs_stat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clk cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic step_clk();
		@(posedge clk);
		#1;
	endtask

	// One full TCK period with tdo sampled just before the rising edge
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (HALF_TCK) step_clk();
		tdo_v = tdo;
		tck = 1'b1;
		repeat (HALF_TCK) step_clk();
	endtask

	task automatic load_ir(input logic [3:0] code);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < 4; i++) begin
			tck_cycle(i == 3, code[i], b);
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	// From Run-Test-Idle through a DR scan and back
	task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic reset_by_tms();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	initial begin
		logic [63:0] dout;
		logic [31:0] cdr_prev;
		logic [15:0] prbs_prev;
		logic b;

		seed = 32'h5fb2_6475;
		errors = 0;
		cycles = 0;
		reset = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		cdr_stat = '0;
		prbs_stat = '0;

		// IDCODE straight after reset
		mode_tab[0] = MODE_NO_IR;
		ir_tab[0] = debug_pkg::IR_IDCODE;
		len_tab[0] = 32;
		din_tab[0] = '0;
		stat_tab[0] = '0;
		dout_tab[0] = {32'd0, IDCODE_VALUE};
		cdr_prev = '0;
		prbs_prev = '0;
		cdr_tab[0] = cdr_prev;
		prbs_tab[0] = prbs_prev;

		// Bypass delays by one bit with a leading zero
		mode_tab[1] = MODE_LOAD_IR;
		ir_tab[1] = debug_pkg::IR_BYPASS;
		len_tab[1] = 8;
		din_tab[1] = 64'hb5;
		stat_tab[1] = '0;
		dout_tab[1] = {56'd0, din_tab[1][6:0], 1'b0};
		cdr_tab[1] = cdr_prev;
		prbs_tab[1] = prbs_prev;

		// Two CDR scans then two PRBS scans
		for (int e = 2; e < 6; e++) begin
			mode_tab[e] = MODE_LOAD_IR;
			din_tab[e] = {$random(seed), $random(seed)};
			stat_tab[e] = $random(seed);
			if (e < 4) begin
				ir_tab[e] = debug_pkg::IR_CDR_DBG;
				len_tab[e] = 64;
				dout_tab[e] = {cdr_prev, stat_tab[e]};
				cdr_prev = din_tab[e][63:32];
			end else begin
				ir_tab[e] = debug_pkg::IR_PRBS_DBG;
				len_tab[e] = 48;
				din_tab[e][63:48] = '0;
				dout_tab[e] = {16'd0, prbs_prev, stat_tab[e]};
				prbs_prev = din_tab[e][47:32];
			end
			cdr_tab[e] = cdr_prev;
			prbs_tab[e] = prbs_prev;
		end

		// TMS reset brings back IDCODE and keeps the controls
		mode_tab[6] = MODE_TMS_RESET;
		ir_tab[6] = debug_pkg::IR_IDCODE;
		len_tab[6] = 32;
		din_tab[6] = '0;
		stat_tab[6] = '0;
		dout_tab[6] = {32'd0, IDCODE_VALUE};
		cdr_tab[6] = cdr_prev;
		prbs_tab[6] = prbs_prev;

		repeat (2) step_clk();
		reset = 1'b0;
		step_clk();
		tck_cycle(1'b0, 1'b0, b);

		for (int e = 0; e < N_ENTRIES; e++) begin
			if (ir_tab[e] == debug_pkg::IR_CDR_DBG) begin
				cdr_stat = stat_tab[e];
			end else if (ir_tab[e] == debug_pkg::IR_PRBS_DBG) begin
				prbs_stat = stat_tab[e];
			end
			if (mode_tab[e] == MODE_LOAD_IR) begin
				load_ir(ir_tab[e]);
			end else if (mode_tab[e] == MODE_TMS_RESET) begin
				reset_by_tms();
			end
			scan_dr(len_tab[e], din_tab[e], dout);
			assert (dout == dout_tab[e]) else begin
				errors++;
				$display("CHECK FAILED at %0t: entry %0d shifted out %h, expected %h",
					$time, e, dout, dout_tab[e]);
			end
			assert (cdr_ctrl == cdr_tab[e]) else begin
				errors++;
				$display("CHECK FAILED at %0t: entry %0d cdr_ctrl %h, expected %h",
					$time, e, cdr_ctrl, cdr_tab[e]);
			end
			assert (prbs_ctrl == prbs_tab[e]) else begin
				errors++;
				$display("CHECK FAILED at %0t: entry %0d prbs_ctrl %h, expected %h",
					$time, e, prbs_ctrl, prbs_tab[e]);
			end
		end

		// TRST pulse clears both controls
		trst_n = 1'b0;
		repeat (4) step_clk();
		trst_n = 1'b1;
		repeat (4) step_clk();
		assert (cdr_ctrl == '0 && prbs_ctrl == '0) else begin
			errors++;
			$display("CHECK FAILED at %0t: controls %h %h not cleared by trst_n",
				$time, cdr_ctrl, prbs_ctrl);
		end

		$display("Errors: %0d, assertion failures: %0d", errors,
			UUT.u_tap.u_checker.fail_count);
		errors += UUT.u_tap.u_checker.fail_count;
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/jtag_hub_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_hub_checker (
	input wire logic clk,
	input wire logic tap_reset_i,
	input wire debug_pkg::tap_strobe_t strobe_i
);
	// Count of failed assertions
	int fail_count = 0;

	// At most one DR action per TCK edge
	assert property (@(posedge clk) disable iff (tap_reset_i)
		$onehot0({strobe_i.capture_dr, strobe_i.shift_dr, strobe_i.update_dr}))
	else begin
		fail_count++;
		$error("TAP strobes capture, shift and update were active together");
	end

	// Each strobe is a single clk pulse
	assert property (@(posedge clk) disable iff (tap_reset_i)
		strobe_i.capture_dr |=> !strobe_i.capture_dr)
	else begin
		fail_count++;
		$error("Capture-DR strobe lasted more than one clk cycle");
	end

	assert property (@(posedge clk) disable iff (tap_reset_i)
		strobe_i.shift_dr |=> !strobe_i.shift_dr)
	else begin
		fail_count++;
		$error("Shift-DR strobe lasted more than one clk cycle");
	end

	assert property (@(posedge clk) disable iff (tap_reset_i)
		strobe_i.update_dr |=> !strobe_i.update_dr)
	else begin
		fail_count++;
		$error("Update-DR strobe lasted more than one clk cycle");
	end

	// IDCODE is the instruction right after reset
	assert property (@(posedge clk) tap_reset_i |=> (strobe_i.ir == debug_pkg::IR_IDCODE))
	else begin
		fail_count++;
		$error("Instruction register was not IDCODE one cycle after reset");
	end

endmodule

bind tap_fsm jtag_hub_checker u_checker (
	.clk(clk),
	.tap_reset_i(tap_reset_o),
	.strobe_i(strobe_o)
);

`default_nettype wire

/* design/jtag_hub.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_hub #(
	parameter logic [31:0] IDCODE_VALUE = 32'h1000_1c5b
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	output debug_pkg::cdr_ctrl_t cdr_ctrl_o,
	output debug_pkg::prbs_ctrl_t prbs_ctrl_o,
	input wire debug_pkg::cdr_stat_t cdr_stat_i,
	input wire debug_pkg::prbs_stat_t prbs_stat_i
);
	debug_pkg::tap_strobe_t tap_strobe;
	logic tck_fall;
	logic ir_bit;
	logic tap_reset;
	logic cdr_sel;
	logic prbs_sel;
	logic cdr_so;
	logic prbs_so;

	tap_fsm u_tap (
		.clk(clk),
		.reset_i(reset_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.strobe_o(tap_strobe),
		.tck_fall_o(tck_fall),
		.ir_bit_o(ir_bit),
		.tap_reset_o(tap_reset)
	);

	// Chain decode
	assign cdr_sel = (tap_strobe.ir == debug_pkg::IR_CDR_DBG);
	assign prbs_sel = (tap_strobe.ir == debug_pkg::IR_PRBS_DBG);

	dbg_scan_chain #(
		.ctrl_t(debug_pkg::cdr_ctrl_t),
		.stat_t(debug_pkg::cdr_stat_t)
	) u_cdr_chain (
		.clk(clk),
		.reset_i(tap_reset),
		.strobe_i(tap_strobe),
		.sel_i(cdr_sel),
		.stat_i(cdr_stat_i),
		.ctrl_o(cdr_ctrl_o),
		.so_o(cdr_so)
	);

	dbg_scan_chain #(
		.ctrl_t(debug_pkg::prbs_ctrl_t),
		.stat_t(debug_pkg::prbs_stat_t)
	) u_prbs_chain (
		.clk(clk),
		.reset_i(tap_reset),
		.strobe_i(tap_strobe),
		.sel_i(prbs_sel),
		.stat_i(prbs_stat_i),
		.ctrl_o(prbs_ctrl_o),
		.so_o(prbs_so)
	);

	tdo_combiner #(
		.IDCODE_VALUE(IDCODE_VALUE)
	) u_tdo (
		.clk(clk),
		.reset_i(tap_reset),
		.strobe_i(tap_strobe),
		.tck_fall_i(tck_fall),
		.ir_bit_i(ir_bit),
		.cdr_so_i(cdr_so),
		.prbs_so_i(prbs_so),
		.tdo_o(tdo_o)
	);

endmodule

`default_nettype wire

/* design/tdo_combiner.sv */
`timescale 1ns/10ps
`default_nettype none

module tdo_combiner #(
	parameter logic [31:0] IDCODE_VALUE = 32'h1000_1c5b
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire debug_pkg::tap_strobe_t strobe_i,
	input wire logic tck_fall_i,
	input wire logic ir_bit_i,
	input wire logic cdr_so_i,
	input wire logic prbs_so_i,
	output logic tdo_o
);
	logic [31:0] idcode_q;
	logic bypass_q;
	logic idcode_sel;
	logic bypass_sel;
	logic dr_bit;
	logic dr_active;

	// Serial source for the current instruction
	always_comb begin
		idcode_sel = 1'b0;
		bypass_sel = 1'b0;
		case (strobe_i.ir)
			debug_pkg::IR_IDCODE: begin
				idcode_sel = 1'b1;
				dr_bit = idcode_q[0];
			end
			debug_pkg::IR_CDR_DBG:  dr_bit = cdr_so_i;
			debug_pkg::IR_PRBS_DBG: dr_bit = prbs_so_i;
			default: begin
				bypass_sel = 1'b1;
				dr_bit = bypass_q;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (idcode_sel && strobe_i.capture_dr) begin
			idcode_q <= IDCODE_VALUE;
		end else if (idcode_sel && strobe_i.shift_dr) begin
			idcode_q <= {strobe_i.tdi_bit, idcode_q[31:1]};
		end
	end

	// Single bit, captures zero
	always_ff @(posedge clk) begin
		if (bypass_sel && strobe_i.capture_dr) begin
			bypass_q <= 1'b0;
		end else if (bypass_sel && strobe_i.shift_dr) begin
			bypass_q <= strobe_i.tdi_bit;
		end
	end

	// Set between Capture-DR and Update-DR, the DR column of the TAP
	always_ff @(posedge clk) begin
		if (reset_i) begin
			dr_active <= 1'b0;
		end else if (strobe_i.capture_dr) begin
			dr_active <= 1'b1;
		end else if (strobe_i.update_dr) begin
			dr_active <= 1'b0;
		end
	end

	// Retimed on the falling TCK edge
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			tdo_o <= dr_active ? dr_bit : ir_bit_i;
		end
	end

endmodule

`default_nettype wire

/* design/dbg_scan_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_scan_chain #(
	parameter type ctrl_t = logic [15:0],
	parameter type stat_t = logic [15:0]
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire debug_pkg::tap_strobe_t strobe_i,
	input wire logic sel_i,
	input wire stat_t stat_i,
	output ctrl_t ctrl_o,
	output logic so_o
);
	localparam int CTRL_W = $bits(ctrl_t);
	localparam int STAT_W = $bits(stat_t);
	localparam int CHAIN_W = CTRL_W + STAT_W;

	logic [CHAIN_W-1:0] chain_q;
	ctrl_t ctrl_q;

	// Control sits above status, status bits leave first
	always_ff @(posedge clk) begin
		if (sel_i) begin
			if (strobe_i.capture_dr) begin
				chain_q <= {ctrl_q, stat_i};
			end else if (strobe_i.shift_dr) begin
				chain_q <= {strobe_i.tdi_bit, chain_q[CHAIN_W-1:1]};
			end
		end
	end

	// Only the control part is written back
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctrl_q <= '0;
		end else if (sel_i && strobe_i.update_dr) begin
			ctrl_q <= ctrl_t'(chain_q[CHAIN_W-1 -: CTRL_W]);
		end
	end

	assign ctrl_o = ctrl_q;
	assign so_o = chain_q[0];

endmodule

`default_nettype wire

/* design/tap_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module tap_fsm (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output debug_pkg::tap_strobe_t strobe_o,
	output logic tck_fall_o,
	output logic ir_bit_o,
	output logic tap_reset_o
);
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	// Fixed 01 pattern loaded in Capture-IR
	localparam logic [debug_pkg::IR_WIDTH-1:0] IR_CAPTURE = 1;

	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_sync;
	logic tck_d;
	logic tck_rise;
	tap_state_t state;
	tap_state_t state_nxt;
	logic [debug_pkg::IR_WIDTH-1:0] ir_q;
	logic [debug_pkg::IR_WIDTH-1:0] ir_shift;

	// JTAG pins into the clk domain
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tck_sync <= 2'b00;
			tms_sync <= 2'b11;
			tdi_sync <= 2'b00;
			trst_sync <= 2'b11;
			tck_d <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], tck_i};
			tms_sync <= {tms_sync[0], tms_i};
			tdi_sync <= {tdi_sync[0], tdi_i};
			trst_sync <= {trst_sync[0], trst_n_i};
			tck_d <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] & ~tck_d;
	assign tck_fall_o = ~tck_sync[1] & tck_d;
	assign tap_reset_o = reset_i | ~trst_sync[1];

	// IEEE 1149.1 transitions
	always_comb begin
		case (state)
			TEST_LOGIC_RESET: state_nxt = tms_sync[1] ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_nxt = tms_sync[1] ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_DR:        state_nxt = tms_sync[1] ? SELECT_IR : CAPTURE_DR;
			CAPTURE_DR:       state_nxt = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_nxt = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_nxt = tms_sync[1] ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_nxt = tms_sync[1] ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_nxt = tms_sync[1] ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_nxt = tms_sync[1] ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_IR:        state_nxt = tms_sync[1] ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_nxt = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_nxt = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_nxt = tms_sync[1] ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_nxt = tms_sync[1] ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_nxt = tms_sync[1] ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_nxt = tms_sync[1] ? SELECT_DR : RUN_TEST_IDLE;
			default:          state_nxt = TEST_LOGIC_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (tap_reset_o) begin
			state <= TEST_LOGIC_RESET;
		end else if (tck_rise) begin
			state <= state_nxt;
		end
	end

	// Instruction register, IDCODE whenever the TAP sits in reset
	always_ff @(posedge clk) begin
		if (tap_reset_o) begin
			ir_q <= debug_pkg::IR_IDCODE;
			ir_shift <= '0;
		end else if (state == TEST_LOGIC_RESET) begin
			ir_q <= debug_pkg::IR_IDCODE;
		end else if (tck_rise) begin
			case (state)
				CAPTURE_IR: ir_shift <= IR_CAPTURE;
				SHIFT_IR:   ir_shift <= {tdi_sync[1], ir_shift[debug_pkg::IR_WIDTH-1:1]};
				UPDATE_IR:  ir_q <= ir_shift;
				default:    ;
			endcase
		end
	end

	// Actions happen on the rising edge that leaves the state
	always_comb begin
		strobe_o.capture_dr = tck_rise && (state == CAPTURE_DR);
		strobe_o.shift_dr = tck_rise && (state == SHIFT_DR);
		strobe_o.update_dr = tck_rise && (state == UPDATE_DR);
		strobe_o.tdi_bit = tdi_sync[1];
		strobe_o.ir = ir_q;
	end

	assign ir_bit_o = ir_shift[0];

endmodule

`default_nettype wire

/* design/debug_pkg.sv */
`default_nettype none

package debug_pkg;

	localparam int IR_WIDTH = 4;

	// Instruction codes, anything unlisted acts as bypass
	localparam logic [IR_WIDTH-1:0] IR_IDCODE   = 4'd1;
	localparam logic [IR_WIDTH-1:0] IR_CDR_DBG  = 4'd2;
	localparam logic [IR_WIDTH-1:0] IR_PRBS_DBG = 4'd3;
	localparam logic [IR_WIDTH-1:0] IR_BYPASS   = 4'd15;

	// One TCK rising edge as seen on clk
	typedef struct packed {
		logic                capture_dr;
		logic                shift_dr;
		logic                update_dr;
		logic                tdi_bit;
		logic [IR_WIDTH-1:0] ir;
	} tap_strobe_t;

	// CDR loop controls
	typedef struct packed {
		logic [3:0]  ki;
		logic [3:0]  kp;
		logic        en_ext_pi_ctl;
		logic [8:0]  ext_pi_ctl;
		logic        en_freq_est;
		logic        invert;
		logic [11:0] pd_offset_ext;
	} cdr_ctrl_t;

	// CDR loop status
	typedef struct packed {
		logic [15:0] phase_est;
		logic [15:0] freq_est;
	} cdr_stat_t;

	// PRBS checker controls
	typedef struct packed {
		logic       prbs_cke;
		logic [7:0] prbs_eqn;
		logic [3:0] prbs_chan_sel;
		logic [1:0] prbs_checker_mode;
		logic       prbs_inv_chicken;
	} prbs_ctrl_t;

	// PRBS checker counters
	typedef struct packed {
		logic [15:0] prbs_err_bits;
		logic [15:0] prbs_total_bits;
	} prbs_stat_t;

endpackage

`default_nettype wire
